// ==== Makefile ====
# Verilator flow for the system controller testbench.
VERILATOR  ?= verilator
FILELIST   ?= sysctl_soc.f
TOP        ?= sysctl_tb
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a non-zero exit status.
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sysctl_soc.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/sysctl_pkg.sv
verilog/sysctl_gpio.sv
verilog/sysctl_timer.sv
verilog/sysctl_csr.sv
verilog/sysctl_top.sv
verification/sysctl_clkgen.sv
verification/sysctl_tb.sv

// ==== verification/sysctl_clkgen.sv ====
// Fixed 4 ns period. Reset is released on a falling edge after four rising edges.
`timescale 1ns/100ps

module sysctl_clkgen (
	output logic sys_clk,
	output logic sys_rst
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk; // Half of the 4 ns period.
	end

	initial begin
		sys_rst = 1'b1;
		repeat (4) @(posedge sys_clk); // Four reset cycles.
		@(negedge sys_clk);
		sys_rst = 1'b0; // Away from the sampling edge.
	end

endmodule

// ==== verification/sysctl_tb.sv ====
// Assumes 16-bit GPIO ports and the default base. Compare values stay below 20 so waits stay short.
`timescale 1ns/100ps
`include "sysctl_defines.svh"

module sysctl_tb;

	import csr_pkg::*;
	import sysctl_pkg::*;

	typedef enum {OP_WRITE, OP_READ, OP_SET_INPUTS, OP_WAIT_IRQ, OP_IDLE} op_e;

	// One row of the stimulus table.
	typedef struct {
		string       name;
		op_e         op;
		logic [3:0]  base;     // Address bits 13:10.
		csr_reg_e    offset;
		logic [31:0] data;     // Write data, pins, irq mask or cycle count.
		logic [31:0] expected; // Read value, edge count or quiet irq vector.
	} entry_t;

	localparam int RESET_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 200;   // Longest timer period is 20 cycles.
	localparam logic [31:0] IRQ_NONE = 32'd0;
	localparam logic [31:0] IRQ_GPIO = 32'b100; // Packed order gpio, timer0, timer1.
	localparam logic [31:0] IRQ_T0 = 32'b010;
	localparam logic [31:0] IRQ_T1 = 32'b001;

	logic                        sys_clk;
	logic                        sys_rst;
	csr_req_t                    csr_req;
	logic [31:0]                 csr_do;
	logic [`SYSCTL_NINPUTS-1:0]  gpio_inputs;
	logic [`SYSCTL_NOUTPUTS-1:0] gpio_outputs;
	sysctl_irq_t                 irq;
	logic [31:0]                 lfsr_state = 32'hd063_d3a6;
	entry_t                      steps[$];

	sysctl_clkgen clkgen (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst)
	);

	sysctl_top dut (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_req      (csr_req),
		.csr_do       (csr_do),
		.gpio_inputs  (gpio_inputs),
		.gpio_outputs (gpio_outputs),
		.irq          (irq)
	);

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit returned.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int          b;
		v = '0;
		for (b = 0; b < n; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected %08h actual %08h",
				name, expected, actual));
	endtask

	task automatic check_irq(input string name, input sysctl_irq_t expected,
		input sysctl_irq_t actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected irq %03b actual irq %03b",
				name, expected, actual));
	endtask

	task automatic check_gpio(input string name, input logic [`SYSCTL_NOUTPUTS-1:0] expected,
		input logic [`SYSCTL_NOUTPUTS-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected pins %h actual pins %h",
				name, expected, actual));
	endtask

	task automatic add_step(input string name, input op_e op, input csr_reg_e offset,
		input logic [31:0] data, input logic [31:0] expected,
		input logic [3:0] base = `SYSCTL_CSR_BASE);
		entry_t e;
		e.name = name;
		e.op = op;
		e.base = base;
		e.offset = offset;
		e.data = data;
		e.expected = expected;
		steps.push_back(e);
	endtask

	// Expected values come from a register model kept while the table is built.
	task automatic build_steps();
		logic [31:0] outv;  // Model of the output latch.
		logic [31:0] inv;   // Model of the synchronized inputs.
		logic [31:0] k0;
		logic [31:0] k1;
		int          j;
		add_step("reset irqen", OP_READ, REG_GPIO_IRQEN, 0, 0);
		add_step("reset t0 ctrl", OP_READ, REG_T0_CTRL, 0, 0);
		add_step("reset t0 counter", OP_READ, REG_T0_COUNTER, 0, 0);
		add_step("reset t0 compare", OP_READ, REG_T0_COMPARE, 0, 32'hffff_ffff);
		add_step("reset t1 ctrl", OP_READ, REG_T1_CTRL, 0, 0);
		add_step("reset t1 counter", OP_READ, REG_T1_COUNTER, 0, 0);
		add_step("reset t1 compare", OP_READ, REG_T1_COMPARE, 0, 32'hffff_ffff);
		add_step("system id", OP_READ, REG_SYSTEMID, 0, `SYSCTL_SYSTEMID);
		for (j = 0; j < 16; j++) begin
			if (j == 3 || j == 7 || (j >= 11 && j <= 14))
				add_step($sformatf("unmapped offset %0d", j), OP_READ,
					csr_reg_e'(4'(j)), 0, 0);
		end
		add_step("foreign base", OP_READ, REG_SYSTEMID, 0, 0, 4'(`SYSCTL_CSR_BASE + 4'd1));

		for (j = 0; j < 2; j++) begin
			outv = random_bits(`SYSCTL_NOUTPUTS);
			add_step($sformatf("gpio out write %0d", j), OP_WRITE, REG_GPIO_OUT, outv, 0);
			add_step($sformatf("gpio out read %0d", j), OP_READ, REG_GPIO_OUT, 0, outv);
		end
		for (j = 0; j < 3; j++) begin
			inv = random_bits(`SYSCTL_NINPUTS);
			add_step($sformatf("gpio in apply %0d", j), OP_SET_INPUTS, REG_GPIO_IN, inv, 0);
			add_step($sformatf("gpio in settle %0d", j), OP_IDLE, REG_GPIO_IN, 2, IRQ_NONE);
			add_step($sformatf("gpio in read %0d", j), OP_READ, REG_GPIO_IN, 0, inv);
		end

		add_step("irqen write", OP_WRITE, REG_GPIO_IRQEN, 32'h0000_00f0, 0);
		add_step("irqen read", OP_READ, REG_GPIO_IRQEN, 0, 32'h0000_00f0);
		inv = inv ^ 32'h0000_0010; // Bit 4 is enabled.
		add_step("enabled change", OP_SET_INPUTS, REG_GPIO_IN, inv, 0);
		add_step("enabled change irq", OP_WAIT_IRQ, REG_GPIO_IN, IRQ_GPIO, 3);
		add_step("single gpio pulse", OP_IDLE, REG_GPIO_IN, 4, IRQ_NONE);
		inv = inv ^ 32'h0000_0100; // Bit 8 is masked.
		add_step("masked change", OP_SET_INPUTS, REG_GPIO_IN, inv, 0);
		add_step("masked change quiet", OP_IDLE, REG_GPIO_IN, 6, IRQ_NONE);
		add_step("masked change read", OP_READ, REG_GPIO_IN, 0, inv);

		k0 = 32'd4 + random_bits(4);
		add_step("t0 counter load", OP_WRITE, REG_T0_COUNTER, 0, 0);
		add_step("t0 compare load", OP_WRITE, REG_T0_COMPARE, k0, 0);
		add_step("t0 start one shot", OP_WRITE, REG_T0_CTRL, 32'h4, 0);
		add_step("t0 match latency", OP_WAIT_IRQ, REG_T0_CTRL, IRQ_T0, k0 + 32'd1);
		add_step("t0 single pulse", OP_IDLE, REG_T0_CTRL, 2, IRQ_NONE);
		add_step("t0 stopped and trig", OP_READ, REG_T0_CTRL, 0, 32'h1);
		add_step("t0 counter held", OP_READ, REG_T0_COUNTER, 0, k0);
		add_step("t0 trig clear", OP_WRITE, REG_T0_CTRL, 0, 0);
		add_step("t0 ctrl cleared", OP_READ, REG_T0_CTRL, 0, 0);

		k1 = 32'd4 + random_bits(4);
		add_step("t1 counter load", OP_WRITE, REG_T1_COUNTER, 0, 0);
		add_step("t1 compare load", OP_WRITE, REG_T1_COMPARE, k1, 0);
		add_step("t1 start reload", OP_WRITE, REG_T1_CTRL, 32'h6, 0);
		add_step("t1 first pulse", OP_WAIT_IRQ, REG_T1_CTRL, IRQ_T1, k1 + 32'd1);
		add_step("t1 period", OP_WAIT_IRQ, REG_T1_CTRL, IRQ_T1, k1);
		// Counter runs 1 to K and wraps back to 1.
		for (j = 0; j < int'(k1) + 2; j++)
			add_step($sformatf("t1 counter %0d", j), OP_READ, REG_T1_COUNTER, 0,
				32'((j % int'(k1)) + 1));
		add_step("t1 period after reads", OP_WAIT_IRQ, REG_T1_CTRL, IRQ_T1, k1 - 32'd2);
		add_step("t0 still idle", OP_READ, REG_T0_CTRL, 0, 0);
		add_step("t0 counter unchanged", OP_READ, REG_T0_COUNTER, 0, k0);
		add_step("t1 running ctrl", OP_READ, REG_T1_CTRL, 0, 32'h7);
		add_step("t1 stop", OP_WRITE, REG_T1_CTRL, 0, 0);
		add_step("t1 stopped", OP_READ, REG_T1_CTRL, 0, 0);
	endtask

	task automatic drive_req(input logic [3:0] base, input csr_reg_e offset, input logic we,
		input logic [31:0] wdata);
		csr_req.addr = {base, 6'd0, offset};
		csr_req.we = we;
		csr_req.wdata = wdata;
	endtask

	// Rising edge for the DUT, then back to the falling edge for the testbench.
	task automatic next_cycle();
		@(posedge sys_clk);
		@(negedge sys_clk);
	endtask

	// Starts and ends on a falling edge.
	task automatic apply_step(input entry_t st);
		sysctl_irq_t want;
		int          n;
		want = sysctl_irq_t'(st.data[2:0]);
		n = 0;
		case (st.op)
			OP_WRITE: begin
				drive_req(st.base, st.offset, 1'b1, st.data);
				next_cycle();
				csr_req.we = 1'b0;
			end
			OP_READ: begin
				drive_req(st.base, st.offset, 1'b0, 32'd0);
				next_cycle();
				check_word(st.name, st.expected, csr_do);
				if (st.offset == REG_GPIO_OUT)
					check_gpio(st.name, st.expected[`SYSCTL_NOUTPUTS-1:0], gpio_outputs);
			end
			OP_SET_INPUTS: gpio_inputs = st.data[`SYSCTL_NINPUTS-1:0];
			OP_WAIT_IRQ: begin
				do begin
					next_cycle();
					n++;
				end while ((irq & want) == 3'b000 && n < IRQ_TIMEOUT);
				if ((irq & want) == 3'b000)
					fail_run($sformatf("%s: the interrupt never arrived within %0d cycles",
						st.name, IRQ_TIMEOUT));
				check_word(st.name, st.expected, 32'(n)); // Edges since the step began.
				check_irq(st.name, want, irq);            // No other source fired.
			end
			OP_IDLE: begin
				for (n = 0; n < int'(st.data); n++) begin
					next_cycle();
					check_irq(st.name, sysctl_irq_t'(st.expected[2:0]), irq);
				end
			end
			default: fail_run("the stimulus table holds an unknown operation");
		endcase
	endtask

	initial begin
		int waited;
		csr_req = '0;
		gpio_inputs = '0;
		waited = 0;
		build_steps();
		@(posedge sys_clk);
		while (sys_rst) begin
			if (waited == RESET_TIMEOUT)
				fail_run("reset was never released");
			@(posedge sys_clk);
			waited++;
		end
		@(negedge sys_clk);
		check_irq("reset irq", '0, irq);
		check_gpio("reset outputs", '0, gpio_outputs);
		foreach (steps[i])
			apply_step(steps[i]);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== verilog/csr_pkg.sv ====
// Offsets live in address bits 3:0. Offsets 3, 7, 11 to 14 are unmapped and read as zero.
package csr_pkg;

	// One bus request, sampled every cycle.
	typedef struct packed {
		logic [13:0] addr;  // Bits 13:10 select the block.
		logic        we;    // Write in this cycle.
		logic [31:0] wdata; // Write data.
	} csr_req_t;

	// Register map of the system controller.
	typedef enum logic [3:0] {
		REG_GPIO_IN     = 4'd0,  // Synchronized inputs, read only.
		REG_GPIO_OUT    = 4'd1,  // Output latch.
		REG_GPIO_IRQEN  = 4'd2,  // Per-bit change enable.
		REG_T0_CTRL     = 4'd4,  // Bit 0 trig, bit 1 ar, bit 2 en.
		REG_T0_COMPARE  = 4'd5,
		REG_T0_COUNTER  = 4'd6,
		REG_T1_CTRL     = 4'd8,  // Same layout as timer 0.
		REG_T1_COMPARE  = 4'd9,
		REG_T1_COUNTER  = 4'd10,
		REG_SYSTEMID    = 4'd15  // Constant, read only.
	} csr_reg_e;

endpackage

// ==== verilog/sysctl_csr.sv ====
// Only address bits 3:0 are decoded. The registers alias across the rest of the window.
`timescale 1ns/100ps
`include "sysctl_defines.svh"

module sysctl_csr (
	input  logic                    sys_clk,
	input  logic                    sys_rst,
	input  csr_pkg::csr_req_t       req,
	output logic [31:0]             csr_do,
	output sysctl_pkg::gpio_cmd_t   gpio_cmd,
	input  sysctl_pkg::gpio_stat_t  gpio_stat,
	output sysctl_pkg::timer_cmd_t  t0_cmd,
	output sysctl_pkg::timer_cmd_t  t1_cmd,
	input  sysctl_pkg::timer_stat_t t0_stat,
	input  sysctl_pkg::timer_stat_t t1_stat
);

	import csr_pkg::*;
	import sysctl_pkg::*;

	logic        selected; // Base matches.
	logic        wr;       // Write to this block.
	csr_reg_e    offset;
	logic [31:0] rdata;    // Unregistered read mux.

	// Control word layout for readback.
	function automatic logic [31:0] ctrl_word(input timer_stat_t s);
		return {29'd0, s.en, s.ar, s.trig};
	endfunction

	assign selected = (req.addr[13:10] == `SYSCTL_CSR_BASE);
	assign wr = selected & req.we;
	assign offset = csr_reg_e'(req.addr[3:0]);

	// Write strobes, valid in the request cycle.
	always_comb begin
		gpio_cmd = '0;
		t0_cmd = '0;
		t1_cmd = '0;
		gpio_cmd.wdata = req.wdata; // Data fans out to all blocks.
		t0_cmd.wdata = req.wdata;
		t1_cmd.wdata = req.wdata;
		if (wr) begin
			case (offset)
				REG_GPIO_OUT:   gpio_cmd.wr_out = 1'b1;
				REG_GPIO_IRQEN: gpio_cmd.wr_irqen = 1'b1;
				REG_T0_CTRL:    t0_cmd.wr_ctrl = 1'b1;
				REG_T0_COMPARE: t0_cmd.wr_compare = 1'b1;
				REG_T0_COUNTER: t0_cmd.wr_counter = 1'b1;
				REG_T1_CTRL:    t1_cmd.wr_ctrl = 1'b1;
				REG_T1_COMPARE: t1_cmd.wr_compare = 1'b1;
				REG_T1_COUNTER: t1_cmd.wr_counter = 1'b1;
				default: ; // Inputs and ID are read only.
			endcase
		end
	end

	// Read mux sees state from before this cycle's write.
	always_comb begin
		case (offset)
			REG_GPIO_IN:    rdata = gpio_stat.in_sync;
			REG_GPIO_OUT:   rdata = gpio_stat.outputs;
			REG_GPIO_IRQEN: rdata = gpio_stat.irqen;
			REG_T0_CTRL:    rdata = ctrl_word(t0_stat);
			REG_T0_COMPARE: rdata = t0_stat.compare;
			REG_T0_COUNTER: rdata = t0_stat.counter;
			REG_T1_CTRL:    rdata = ctrl_word(t1_stat);
			REG_T1_COMPARE: rdata = t1_stat.compare;
			REG_T1_COUNTER: rdata = t1_stat.counter;
			REG_SYSTEMID:   rdata = `SYSCTL_SYSTEMID;
			default:        rdata = 32'd0; // Unmapped.
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_do <= 32'd0;
		else
			csr_do <= selected ? rdata : 32'd0; // Quiet when not addressed.
	end

	// At most one register may change per request across all blocks.
	a_one_strobe: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$onehot0({gpio_cmd.wr_out, gpio_cmd.wr_irqen,
			t0_cmd.wr_ctrl, t0_cmd.wr_compare, t0_cmd.wr_counter,
			t1_cmd.wr_ctrl, t1_cmd.wr_compare, t1_cmd.wr_counter}));

endmodule

// ==== verilog/sysctl_defines.svh ====
// GPIO widths must stay between 1 and 32. The base is matched against address bits 13:10 only.
`ifndef SYSCTL_DEFINES_SVH
`define SYSCTL_DEFINES_SVH

// Block select.
`define SYSCTL_CSR_BASE 4'h0 // Compared with csr address bits 13:10.

// GPIO port widths.
`define SYSCTL_NINPUTS  16 // Input pins, at most 32.
`define SYSCTL_NOUTPUTS 16 // Output pins, at most 32.

// Identification.
`define SYSCTL_SYSTEMID 32'habadface // Read at the last offset.

`endif

// ==== verilog/sysctl_gpio.sv ====
// Inputs may be asynchronous. Several bits changing together still give one irq cycle.
`timescale 1ns/100ps
`include "sysctl_defines.svh"

module sysctl_gpio (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic [`SYSCTL_NINPUTS-1:0]  gpio_inputs,
	input  sysctl_pkg::gpio_cmd_t       cmd,
	output logic [`SYSCTL_NOUTPUTS-1:0] gpio_outputs,
	output sysctl_pkg::gpio_stat_t      stat,
	output logic                        irq
);

	logic [`SYSCTL_NINPUTS-1:0] in_meta; // First synchronizer stage.
	logic [`SYSCTL_NINPUTS-1:0] in_sync; // Second stage, safe to use.
	logic [`SYSCTL_NINPUTS-1:0] in_prev; // Last cycle's synchronized value.
	logic [`SYSCTL_NINPUTS-1:0] irqen;   // Change interrupt enables.
	logic [`SYSCTL_NINPUTS-1:0] changed; // Bits that toggled.

	// Synchronizer and history.
	always_ff @(posedge sys_clk) begin
		in_meta <= gpio_inputs;
		in_sync <= in_meta;
		in_prev <= in_sync; // Feeds the edge detector.
	end

	assign changed = in_prev ^ in_sync; // Either edge.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			gpio_outputs <= '0;
			irqen <= '0;
			irq <= 1'b0;
		end else begin
			irq <= |(changed & irqen); // One pulse per change event.
			if (cmd.wr_out)
				gpio_outputs <= cmd.wdata[`SYSCTL_NOUTPUTS-1:0];
			if (cmd.wr_irqen)
				irqen <= cmd.wdata[`SYSCTL_NINPUTS-1:0];
		end
	end

	// Readback, padded to the bus width.
	assign stat = '{
		in_sync: 32'(in_sync),
		outputs: 32'(gpio_outputs),
		irqen:   32'(irqen)
	};

	// The pulse is built from the enables of the cycle before it.
	a_irq_enabled: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |-> ($past(irqen) != '0));

endmodule

// ==== verilog/sysctl_pkg.sv ====
// Status words are fixed at 32 bits. Narrower GPIO ports are zero-extended by the blocks.
package sysctl_pkg;

	// Decoded write to one timer.
	typedef struct packed {
		logic        wr_ctrl;    // Load en and ar, clear trig.
		logic        wr_compare; // Load compare.
		logic        wr_counter; // Load counter.
		logic [31:0] wdata;      // Shared write data.
	} timer_cmd_t;

	// Timer state for readback.
	typedef struct packed {
		logic        en;      // Counting.
		logic        ar;      // Reload to 1 on match.
		logic        trig;    // Sticky match flag.
		logic [31:0] counter;
		logic [31:0] compare;
	} timer_stat_t;

	// Decoded write to the GPIO block.
	typedef struct packed {
		logic        wr_out;   // Load output latch.
		logic        wr_irqen; // Load interrupt enables.
		logic [31:0] wdata;
	} gpio_cmd_t;

	// GPIO state for readback.
	typedef struct packed {
		logic [31:0] in_sync; // After the two flop synchronizer.
		logic [31:0] outputs;
		logic [31:0] irqen;
	} gpio_stat_t;

	// Interrupt pulses leaving the controller.
	typedef struct packed {
		logic gpio;   // Enabled input changed.
		logic timer0; // Timer 0 matched.
		logic timer1; // Timer 1 matched.
	} sysctl_irq_t;

endpackage

// ==== verilog/sysctl_timer.sv ====
// Counting stops only at compare. A compare below the counter is reached after a 32-bit wrap.
`timescale 1ns/100ps

module sysctl_timer (
	input  logic                    sys_clk,
	input  logic                    sys_rst,
	input  sysctl_pkg::timer_cmd_t  cmd,
	output sysctl_pkg::timer_stat_t stat,
	output logic                    irq
);

	logic        en;      // Counting enabled.
	logic        ar;      // Autoreload.
	logic        trig;    // Sticky, cleared by a control write.
	logic [31:0] counter;
	logic [31:0] compare;
	logic        match;   // Counter has reached compare.
	logic        fire;    // Match while running.

	assign match = (counter == compare);
	assign fire = en & match;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			en <= 1'b0;
			ar <= 1'b0;
			trig <= 1'b0;
			counter <= '0;
			compare <= '1; // Far away until software sets it.
			irq <= 1'b0;
		end else begin
			// A control write in the match cycle swallows the event.
			irq <= fire & ~cmd.wr_ctrl;

			if (en & ~match)
				counter <= counter + 32'd1;
			if (fire) begin
				trig <= 1'b1;
				if (ar)
					counter <= 32'd1; // Period is compare cycles.
				else
					en <= 1'b0;       // One shot.
			end

			// Software writes win over the count update.
			if (cmd.wr_ctrl) begin
				trig <= 1'b0;
				ar <= cmd.wdata[1];
				en <= cmd.wdata[2];
			end
			if (cmd.wr_compare)
				compare <= cmd.wdata;
			if (cmd.wr_counter)
				counter <= cmd.wdata;
		end
	end

	assign stat = '{
		en:      en,
		ar:      ar,
		trig:    trig,
		counter: counter,
		compare: compare
	};

	// Every pulse leaves the sticky flag behind.
	a_irq_trig: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |-> trig);

	// The slave decodes a single offset per request.
	a_one_cmd: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$onehot0({cmd.wr_ctrl, cmd.wr_compare, cmd.wr_counter}));

endmodule

// ==== verilog/sysctl_top.sv ====
// Interrupts are single cycle pulses. Software reads the sticky trig bits to recover timer events.
`timescale 1ns/100ps
`include "sysctl_defines.svh"

module sysctl_top (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  csr_pkg::csr_req_t           csr_req,
	output logic [31:0]                 csr_do,
	input  logic [`SYSCTL_NINPUTS-1:0]  gpio_inputs,
	output logic [`SYSCTL_NOUTPUTS-1:0] gpio_outputs,
	output sysctl_pkg::sysctl_irq_t     irq
);

	import sysctl_pkg::*;

	gpio_cmd_t   gpio_cmd;  // Slave to GPIO.
	gpio_stat_t  gpio_stat;
	timer_cmd_t  t0_cmd;    // Slave to timers.
	timer_cmd_t  t1_cmd;
	timer_stat_t t0_stat;
	timer_stat_t t1_stat;
	logic        gpio_irq;
	logic        t0_irq;
	logic        t1_irq;

	sysctl_csr csr (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.req       (csr_req),
		.csr_do    (csr_do),
		.gpio_cmd  (gpio_cmd),
		.gpio_stat (gpio_stat),
		.t0_cmd    (t0_cmd),
		.t1_cmd    (t1_cmd),
		.t0_stat   (t0_stat),
		.t1_stat   (t1_stat)
	);

	sysctl_gpio gpio (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.gpio_inputs  (gpio_inputs),
		.cmd          (gpio_cmd),
		.gpio_outputs (gpio_outputs),
		.stat         (gpio_stat),
		.irq          (gpio_irq)
	);

	sysctl_timer timer0 (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.cmd     (t0_cmd),
		.stat    (t0_stat),
		.irq     (t0_irq)
	);

	sysctl_timer timer1 (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.cmd     (t1_cmd),
		.stat    (t1_stat),
		.irq     (t1_irq)
	);

	assign irq = '{gpio: gpio_irq, timer0: t0_irq, timer1: t1_irq}; // All registered.

endmodule
